//--- rtl/bpu_pkg.sv
/*
 * Shared types and constants of the branch prediction unit.
 * Holds the pipeline-side structs, the two-bit counter state encoding,
 * the APB register map and the statistics counter width.
 * Modules import it inside their bodies and use scoped names in ports.
 */
package bpu_pkg;

   // statistics counter width, both counts saturate at all ones
   localparam int STAT_W = 16;

   // APB bus widths
   localparam int APB_AW = 4;
   localparam int APB_DW = 32;

   // register map, word aligned
   localparam logic [APB_AW-1:0] ADDR_CTRL     = 4'h0; // write 1 to bit 0 clears counts
   localparam logic [APB_AW-1:0] ADDR_STATUS   = 4'h4; // counter state in bits 1:0
   localparam logic [APB_AW-1:0] ADDR_BRANCHES = 4'h8; // resolved conditional branches
   localparam logic [APB_AW-1:0] ADDR_MISPRED  = 4'hC; // reported mispredictions

   localparam int CTRL_CLEAR_BIT = 0;

   // two-bit saturating counter state
   // bit 1 set means the counter leans toward taken
   typedef enum logic [1:0] {
      ST_STRONG_NT = 2'd0, // strongly not taken
      ST_WEAK_NT   = 2'd1, // weakly not taken
      ST_WEAK_T    = 2'd2, // weakly taken, reset state
      ST_STRONG_T  = 2'd3  // strongly taken
   } bpu_state_t;

   // decode stage view, the branch being predicted
   typedef struct packed {
      logic op_bf;  // cur insn is bf
      logic op_bnf; // cur insn is bnf
   } dec_info_t;

   // execute stage view, the branch being resolved
   typedef struct packed {
      logic op_bf;      // resolving insn is bf
      logic op_bnf;     // resolving insn is bnf
      logic flag;       // real compare flag
      logic brcond;     // conditional branch resolves now
      logic mispredict; // pipeline reports a wrong guess
   } exe_info_t;

endpackage

//--- rtl/bpu_sat_fsm.sv
/*
 * Global two-bit saturating counter predictor.
 * The predicted flag is combinational from the current state and the
 * branch type in decode. The state steps toward taken or not taken when
 * execute resolves a conditional branch while the pipeline advances.
 */
module bpu_sat_fsm (
   input  logic                clk,
   input  logic                rst,
   input  bpu_pkg::dec_info_t  dec_i,            // decode branch type
   input  bpu_pkg::exe_info_t  exe_i,            // resolving branch
   input  logic                padv_decode_i,    // pipeline moves
   output logic                predicted_flag_o, // guessed compare flag
   output bpu_pkg::bpu_state_t state_o           // for status readback
);
   import bpu_pkg::*;

   bpu_state_t state_q;
   bpu_state_t state_d;
   logic       resolve;  // conditional branch retires from execute
   logic       brn_taken;

   assign resolve = exe_i.brcond & padv_decode_i;

   // bf jumps on flag set, bnf jumps on flag clear
   assign brn_taken = (exe_i.op_bf & exe_i.flag) | (exe_i.op_bnf & ~exe_i.flag);

   // taken side predicts flag set for bf, not taken side predicts it for bnf
   assign predicted_flag_o = state_q[1] ? dec_i.op_bf : dec_i.op_bnf;

   assign state_o = state_q;

   // next state, saturating at both ends
   always_comb begin
      state_d = state_q;
      if (resolve) begin
         if (brn_taken) begin
            unique case (state_q)
               ST_STRONG_NT: state_d = ST_WEAK_NT;
               ST_WEAK_NT:   state_d = ST_WEAK_T;
               ST_WEAK_T:    state_d = ST_STRONG_T;
               ST_STRONG_T:  state_d = ST_STRONG_T; // already at top
            endcase
         end else begin
            unique case (state_q)
               ST_STRONG_T:  state_d = ST_WEAK_T;
               ST_WEAK_T:    state_d = ST_WEAK_NT;
               ST_WEAK_NT:   state_d = ST_STRONG_NT;
               ST_STRONG_NT: state_d = ST_STRONG_NT; // already at bottom
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= ST_WEAK_T; // start leaning taken
      end else begin
         state_q <= state_d;
      end
   end

endmodule

//--- rtl/bpu_stats.sv
/*
 * Branch statistics.
 * Counts every resolved conditional branch and, of those, the ones the
 * pipeline flags as mispredicted. Both counts stop at all ones.
 * A clear pulse zeroes both and wins over an event in the same cycle.
 */
module bpu_stats (
   input  logic                       clk,
   input  logic                       rst,
   input  bpu_pkg::exe_info_t         exe_i,         // resolving branch
   input  logic                       padv_decode_i, // pipeline moves
   input  logic                       clear_i,       // one cycle clear from regs
   output logic [bpu_pkg::STAT_W-1:0] branches_o,
   output logic [bpu_pkg::STAT_W-1:0] mispred_o
);
   import bpu_pkg::*;

   logic [STAT_W-1:0] branches_q;
   logic [STAT_W-1:0] mispred_q;
   logic              resolve;
   logic              branches_full; // stop counting at all ones
   logic              mispred_full;

   // same event qualifier as the predictor
   assign resolve = exe_i.brcond & padv_decode_i;

   assign branches_full = &branches_q;
   assign mispred_full  = &mispred_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         branches_q <= '0;
      end else if (clear_i) begin
         branches_q <= '0; // clear beats a same cycle event
      end else if (resolve && !branches_full) begin
         branches_q <= branches_q + 1'b1;
      end
   end

   // mispredict only counts when it rides on a resolve event
   always_ff @(posedge clk) begin
      if (rst) begin
         mispred_q <= '0;
      end else if (clear_i) begin
         mispred_q <= '0;
      end else if (resolve && exe_i.mispredict && !mispred_full) begin
         mispred_q <= mispred_q + 1'b1;
      end
   end

   assign branches_o = branches_q;
   assign mispred_o  = mispred_q;

endmodule

//--- rtl/bpu_apb_regs.sv
/*
 * APB register block of the branch prediction unit.
 * Never inserts wait states: the setup phase is decoded and the response
 * is registered, so ready, error and read data show up in the access phase.
 * CTRL bit 0 written as 1 sends a one cycle clear to the statistics.
 */
module bpu_apb_regs (
   input  logic                       clk,
   input  logic                       rst,
   // APB slave
   input  logic                       psel_i,
   input  logic                       penable_i,
   input  logic                       pwrite_i,
   input  logic [bpu_pkg::APB_AW-1:0] paddr_i,
   input  logic [bpu_pkg::APB_DW-1:0] pwdata_i,
   output logic [bpu_pkg::APB_DW-1:0] prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o,
   // core side
   input  bpu_pkg::bpu_state_t        state_i,    // predictor state
   input  logic [bpu_pkg::STAT_W-1:0] branches_i, // resolved count
   input  logic [bpu_pkg::STAT_W-1:0] mispred_i,  // mispredict count
   output logic                       clear_o     // zero both counts
);
   import bpu_pkg::*;

   logic              setup;    // first cycle of a transfer
   logic              addr_hit; // address is in the map
   logic              ctrl_clr; // clear request seen in setup
   logic [APB_DW-1:0] rd_data;

   logic              pready_q;
   logic              pslverr_q;
   logic              clear_q;
   logic [APB_DW-1:0] prdata_q;

   // next cycle is the access phase, master holds the bus stable
   assign setup = psel_i & ~penable_i;

   // address decode, anything off the four words is an error
   always_comb begin
      unique case (paddr_i)
         ADDR_CTRL,
         ADDR_STATUS,
         ADDR_BRANCHES,
         ADDR_MISPRED: addr_hit = 1'b1;
         default:      addr_hit = 1'b0;
      endcase
   end

   // read mux, unused upper bits read zero
   always_comb begin
      rd_data = '0;
      unique case (paddr_i)
         ADDR_STATUS:   rd_data[1:0]        = state_i;
         ADDR_BRANCHES: rd_data[STAT_W-1:0] = branches_i;
         ADDR_MISPRED:  rd_data[STAT_W-1:0] = mispred_i;
         default:       rd_data             = '0; // CTRL reads back zero
      endcase
   end

   // only CTRL is writable, other writes drop silently
   assign ctrl_clr = setup & pwrite_i & (paddr_i == ADDR_CTRL) &
                     pwdata_i[CTRL_CLEAR_BIT];

   always_ff @(posedge clk) begin
      if (rst) begin
         pready_q  <= 1'b0;
         pslverr_q <= 1'b0;
         clear_q   <= 1'b0;
      end else begin
         pready_q  <= setup;             // high for the whole access phase
         pslverr_q <= setup & ~addr_hit; // error only with ready
         clear_q   <= ctrl_clr;          // drops after one cycle
      end
   end

   // captured in setup, so reads see values from before the access edge
   always_ff @(posedge clk) begin
      if (rst) begin
         prdata_q <= '0;
      end else if (setup && !pwrite_i) begin
         prdata_q <= rd_data;
      end else begin
         prdata_q <= '0; // zero outside a read access
      end
   end

   assign pready_o  = pready_q;
   assign pslverr_o = pslverr_q;
   assign prdata_o  = prdata_q;
   assign clear_o   = clear_q;

endmodule

//--- rtl/bpu_top.sv
/*
 * Branch prediction unit top level.
 * Pipeline ports feed the saturating counter and the statistics,
 * the APB port reaches state and counts through the register block.
 */
module bpu_top (
   input  logic                       clk,
   input  logic                       rst,
   // pipeline side
   input  bpu_pkg::dec_info_t         dec_i,
   input  bpu_pkg::exe_info_t         exe_i,
   input  logic                       padv_decode_i,
   output logic                       predicted_flag_o,
   // APB slave
   input  logic                       psel_i,
   input  logic                       penable_i,
   input  logic                       pwrite_i,
   input  logic [bpu_pkg::APB_AW-1:0] paddr_i,
   input  logic [bpu_pkg::APB_DW-1:0] pwdata_i,
   output logic [bpu_pkg::APB_DW-1:0] prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o
);
   import bpu_pkg::*;

   bpu_state_t        state;    // predictor to regs
   logic [STAT_W-1:0] branches; // stats to regs
   logic [STAT_W-1:0] mispred;
   logic              clear;    // regs to stats

   bpu_sat_fsm i_bpu_sat_fsm (
      .clk              (clk),
      .rst              (rst),
      .dec_i            (dec_i),
      .exe_i            (exe_i),
      .padv_decode_i    (padv_decode_i),
      .predicted_flag_o (predicted_flag_o),
      .state_o          (state)
   );

   bpu_stats i_bpu_stats (
      .clk           (clk),
      .rst           (rst),
      .exe_i         (exe_i),
      .padv_decode_i (padv_decode_i),
      .clear_i       (clear),
      .branches_o    (branches),
      .mispred_o     (mispred)
   );

   bpu_apb_regs i_bpu_apb_regs (
      .clk        (clk),
      .rst        (rst),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .state_i    (state),
      .branches_i (branches),
      .mispred_i  (mispred),
      .clear_o    (clear)
   );

endmodule

//--- sim/bpu_chk.sv
/*
 * Bound checks for the branch prediction unit.
 * Attached to bpu_top by the bind below. Watches the APB response timing,
 * the clear pulse and the predictor state.
 */
module bpu_chk (
   input logic       clk,
   input logic       rst,
   input logic       psel_i,
   input logic       penable_i,
   input logic       pready_i,
   input logic       pslverr_i,
   input logic       clear_i,
   input logic [1:0] state_i
);

   logic        access;         // second cycle of a transfer
   int unsigned fail_count = 0; // bumped by every failing assertion

   assign access = psel_i & penable_i;

   // no wait states, ready only in access
   ready_in_access: assert property (@(posedge clk) disable iff (rst)
      pready_i == access)
      else begin
         $error("pready_o does not match the access phase");
         fail_count++;
      end

   err_in_access: assert property (@(posedge clk) disable iff (rst)
      !access |-> !pslverr_i)
      else begin
         $error("pslverr_o high outside an access phase");
         fail_count++;
      end

   clear_one_cycle: assert property (@(posedge clk) disable iff (rst)
      clear_i |=> !clear_i)
      else begin
         $error("clear pulse longer than one cycle");
         fail_count++;
      end

   // counter holds or moves by one, never wraps
   state_step: assert property (@(posedge clk) disable iff (rst)
      ({1'b0, state_i} == {1'b0, $past(state_i)}) ||
      ({1'b0, state_i} == {1'b0, $past(state_i)} + 3'd1) ||
      ({1'b0, $past(state_i)} == {1'b0, state_i} + 3'd1))
      else begin
         $error("predictor state jumped by more than one");
         fail_count++;
      end

endmodule

bind bpu_top bpu_chk i_bpu_chk (
   .clk       (clk),
   .rst       (rst),
   .psel_i    (psel_i),
   .penable_i (penable_i),
   .pready_i  (pready_o),
   .pslverr_i (pslverr_o),
   .clear_i   (clear),
   .state_i   (state)
);

//--- sim/bpu_tb.sv
/*
 * Directed testbench of the branch prediction unit.
 * Drives the pipeline and APB ports of bpu_top, keeps a reference model of
 * the two-bit counter and both counts, and checks prediction, STATUS and
 * the counts after reset, a saturation walk, gating, a random stream
 * and a clear. Run through the Makefile with bpu_tb as top.
 */
module bpu_tb;
   import bpu_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int DRV        = 10;  // input skew after rising edge
   localparam int RST_CYCLES = 8;
   localparam int N_RANDOM   = 200;
   // per test: reset reads, walk steps, gating, random steps, clear and errors
   localparam int TEST_CYCLES = RST_CYCLES + 11 + 11 * 6 + 13 + N_RANDOM * 3 + 6 + 21;
   localparam int WATCHDOG_TIME = 2 * TEST_CYCLES * CLK_PERIOD; // twice the budget

   logic              clk;
   logic              rst;
   dec_info_t         dec_i;
   exe_info_t         exe_i;
   logic              padv_decode_i;
   logic              predicted_flag_o;
   logic              psel_i;
   logic              penable_i;
   logic              pwrite_i;
   logic [APB_AW-1:0] paddr_i;
   logic [APB_DW-1:0] pwdata_i;
   logic [APB_DW-1:0] prdata_o;
   logic              pready_o;
   logic              pslverr_o;

   // reference model
   logic [1:0]  m_state;    // 0 strongly nt .. 3 strongly t
   logic [31:0] m_branches; // saturates at 16 bits
   logic [31:0] m_mispred;
   logic [31:0] lcg_state;

   bpu_top i_bpu_top (
      .clk              (clk),
      .rst              (rst),
      .dec_i            (dec_i),
      .exe_i            (exe_i),
      .padv_decode_i    (padv_decode_i),
      .predicted_flag_o (predicted_flag_o),
      .psel_i           (psel_i),
      .penable_i        (penable_i),
      .pwrite_i         (pwrite_i),
      .paddr_i          (paddr_i),
      .pwdata_i         (pwdata_i),
      .prdata_o         (prdata_o),
      .pready_o         (pready_o),
      .pslverr_o        (pslverr_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // flag the predictor should give for a bf or bnf in decode
   function automatic logic model_pred(input logic is_bf);
      return m_state[1] ? is_bf : !is_bf;
   endfunction

   task automatic check_bit(input string name, input logic exp, input logic act);
      assert (act === exp) else begin
         $display("ERR %0t %s expected %0b got %0b", $time, name, exp, act);
         $display("Simulation failed");
         $fatal(1, "bit mismatch on %s", name);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      assert (act === exp) else begin
         $display("ERR %0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
         $display("Simulation failed");
         $fatal(1, "word mismatch on %s", name);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #DRV;
   endtask

   task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                           output logic err);
      psel_i    = 1'b1; // setup
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = addr;
      next_cycle();
      penable_i = 1'b1; // access
      @(negedge clk);
      check_bit("pready_o", 1'b1, pready_o);
      data = prdata_o;
      err  = pslverr_o;
      next_cycle();
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b1;
      paddr_i   = addr;
      pwdata_i  = data;
      next_cycle();
      penable_i = 1'b1;
      @(negedge clk);
      check_bit("pready_o", 1'b1, pready_o);
      check_bit("pslverr_o", 1'b0, pslverr_o);
      next_cycle();
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   // mapped register read, no error expected
   task automatic read_check(input logic [APB_AW-1:0] addr, input string name,
                             input logic [31:0] exp);
      logic [APB_DW-1:0] data;
      logic              err;
      apb_read(addr, data, err);
      check_bit("pslverr_o", 1'b0, err);
      check_word(name, exp, data);
   endtask

   task automatic model_resolve(input logic is_bf, input logic flag, input logic mispred);
      logic taken;
      taken = (is_bf && flag) || (!is_bf && !flag); // bf on set, bnf on clear
      if (taken && m_state != 2'd3)
         m_state = m_state + 2'd1;
      else if (!taken && m_state != 2'd0)
         m_state = m_state - 2'd1;
      if (m_branches != 32'h0000_ffff)
         m_branches = m_branches + 32'd1;
      if (mispred && m_mispred != 32'h0000_ffff)
         m_mispred = m_mispred + 32'd1;
   endtask

   // one cycle with a branch in execute
   task automatic resolve_branch(input logic is_bf, input logic flag, input logic mispred,
                                 input logic padv, input logic brcond);
      exe_i.op_bf      = is_bf;
      exe_i.op_bnf     = !is_bf;
      exe_i.flag       = flag;
      exe_i.brcond     = brcond;
      exe_i.mispredict = mispred;
      padv_decode_i    = padv;
      if (padv && brcond)
         model_resolve(is_bf, flag, mispred);
      next_cycle();
      exe_i         = '0;
      padv_decode_i = 1'b1;
   endtask

   // bf then bnf in decode, sampled mid cycle
   task automatic check_prediction();
      dec_i.op_bf  = 1'b1;
      dec_i.op_bnf = 1'b0;
      @(negedge clk);
      check_bit("predicted_flag_o (bf)", model_pred(1'b1), predicted_flag_o);
      next_cycle();
      dec_i.op_bf  = 1'b0;
      dec_i.op_bnf = 1'b1;
      @(negedge clk);
      check_bit("predicted_flag_o (bnf)", model_pred(1'b0), predicted_flag_o);
      next_cycle();
      dec_i = '0;
   endtask

   task automatic test_reset_state();
      check_prediction(); // weakly taken, bf 1 and bnf 0
      read_check(ADDR_STATUS, "STATUS", 32'd2);
      read_check(ADDR_BRANCHES, "BRANCHES", 32'd0);
      read_check(ADDR_MISPRED, "MISPRED", 32'd0);
   endtask

   // five taken up to the top, six not taken down to the bottom
   task automatic test_saturation_walk();
      logic is_bf;
      logic taken;
      logic flag;
      for (int i = 0; i < 11; i++) begin
         taken = (i < 5);
         is_bf = (i % 2 == 0); // alternate bf and bnf
         flag  = (is_bf == taken);
         resolve_branch(is_bf, flag, model_pred(is_bf) != flag, 1'b1, 1'b1);
         check_prediction();
         read_check(ADDR_STATUS, "STATUS", {30'd0, m_state});
      end
   endtask

   task automatic test_gating();
      resolve_branch(1'b1, 1'b1, 1'b1, 1'b0, 1'b1); // stalled pipeline
      resolve_branch(1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
      resolve_branch(1'b1, 1'b1, 1'b1, 1'b1, 1'b0); // no cond branch
      resolve_branch(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
      read_check(ADDR_STATUS, "STATUS", {30'd0, m_state});
      read_check(ADDR_BRANCHES, "BRANCHES", m_branches);
      read_check(ADDR_MISPRED, "MISPRED", m_mispred);
   endtask

   task automatic test_random_stream();
      logic [31:0] r;
      for (int n = 0; n < N_RANDOM; n++) begin
         r = lcg_next();
         resolve_branch(r[16], r[17], r[18], 1'b1, 1'b1); // upper bits mix better
         check_prediction();
      end
      read_check(ADDR_BRANCHES, "BRANCHES", m_branches);
      read_check(ADDR_MISPRED, "MISPRED", m_mispred);
   endtask

   task automatic test_clear_and_errors();
      logic [APB_DW-1:0]  data;
      logic               err;
      logic [APB_AW-1:0]  bad_addr [3];
      bad_addr = '{4'h2, 4'h6, 4'he}; // holes between the mapped words
      apb_write(ADDR_CTRL, 32'h1);
      m_branches = 32'd0;
      m_mispred  = 32'd0;
      read_check(ADDR_BRANCHES, "BRANCHES", m_branches);
      read_check(ADDR_MISPRED, "MISPRED", m_mispred);
      read_check(ADDR_STATUS, "STATUS", {30'd0, m_state}); // state survives
      for (int k = 0; k < 3; k++) begin
         apb_read(bad_addr[k], data, err);
         check_bit("pslverr_o", 1'b1, err);
         check_word("prdata_o", 32'd0, data);
      end
   endtask

   initial begin
      clk           = 1'b0;
      rst           = 1'b1;
      dec_i         = '0;
      exe_i         = '0;
      padv_decode_i = 1'b0;
      psel_i        = 1'b0;
      penable_i     = 1'b0;
      pwrite_i      = 1'b0;
      paddr_i       = '0;
      pwdata_i      = '0;
      lcg_state     = 32'd36859;
      m_state       = 2'd2; // weakly taken
      m_branches    = 32'd0;
      m_mispred     = 32'd0;
      repeat (RST_CYCLES) @(posedge clk);
      #DRV;
      rst           = 1'b0;
      padv_decode_i = 1'b1;
      test_reset_state();
      test_saturation_walk();
      test_gating();
      test_random_stream();
      test_clear_and_errors();
      // bound protocol checks count their own failures
      if (i_bpu_top.i_bpu_chk.fail_count == 0) begin
         $display("Simulation passed");
         $finish;
      end else begin
         $display("%0d bound assertion checks failed", i_bpu_top.i_bpu_chk.fail_count);
         $display("Simulation failed");
         $fatal(1, "bound assertion failures");
      end
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("watchdog expired before the tests finished");
      $display("Simulation failed");
      $fatal(1, "timeout");
   end

endmodule

//--- files.f
rtl/bpu_pkg.sv
rtl/bpu_sat_fsm.sv
rtl/bpu_stats.sv
rtl/bpu_apb_regs.sv
rtl/bpu_top.sv
sim/bpu_chk.sv
sim/bpu_tb.sv

//--- Makefile
# Verilator build and run of the branch prediction unit testbench.
# Override any variable on the command line, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= bpu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
